/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_conv_array
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

/* conv_array.sv */
`timescale 1ns/10ps

module conv_array #(
	parameter int KERNELS = 2
) (
	input  logic                                          clk,
	input  logic                                          rst,
	input  conv_pkg::ctrl_t                               ctrl,
	input  logic [conv_pkg::WORD_W-1:0]                   i_data,
	input  logic [conv_pkg::WORD_W-1:0]                   w_data,
	input  logic                                          i_valid,
	input  logic                                          w_valid,
	input  logic                                          stride,
	output conv_pkg::sum_t [KERNELS*conv_pkg::LANES-1:0]  result,
	output logic                                          res_valid,
	output logic                                          finish
);

	logic row_load;  // Shift a new row in
	logic w_load;    // Store next weight word
	logic rotate;    // Compute step
	logic w_clear;   // Weight count restart

	conv_pkg::row_t                 row0;     // Oldest row
	conv_pkg::row_t                 row1;
	conv_pkg::row_t                 row2;
	conv_pkg::kernel_t [KERNELS-1:0] kernels;  // Unpacked 3x3 sets

	conv_ctrl i_ctrl (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl),
		.i_valid   (i_valid),
		.w_valid   (w_valid),
		.row_load  (row_load),
		.w_load    (w_load),
		.rotate    (rotate),
		.w_clear   (w_clear),
		.res_valid (res_valid),
		.finish    (finish)
	);

	conv_row_buffer i_rows (
		.clk      (clk),
		.rst      (rst),
		.i_data   (i_data),
		.row_load (row_load),
		.rotate   (rotate),
		.stride   (stride),
		.row0     (row0),
		.row1     (row1),
		.row2     (row2)
	);

	conv_weight_buffer #(
		.KERNELS (KERNELS)
	) i_weights (
		.clk     (clk),
		.rst     (rst),
		.w_data  (w_data),
		.w_load  (w_load),
		.w_clear (w_clear),
		.kernels (kernels)
	);

	// One cube per kernel and column lane
	for (genvar k = 0; k < KERNELS; k++) begin : g_kernel
		for (genvar c = 0; c < conv_pkg::LANES; c++) begin : g_lane
			conv_window_cube #(
				.COL (c)
			) i_cube (
				.clk    (clk),
				.rst    (rst),
				.row0   (row0),
				.row1   (row1),
				.row2   (row2),
				.kernel (kernels[k]),
				.sum    (result[k*conv_pkg::LANES + c])  // Kernel-major lane order
			);
		end
	end

endmodule

/* conv_array_props.sv */
`timescale 1ns/10ps

module conv_array_props (
	input logic             clk,
	input logic             rst,
	input conv_pkg::ctrl_t  ctrl,
	input conv_pkg::state_t state,
	input logic             res_valid,
	input logic             finish
);

	int n_fail = 0;  // Read by the testbench at the end

	// Outputs held low during reset
	a_reset_low: assert property (@(posedge clk) !rst |-> (!res_valid && !finish))
		else begin
			$error("res_valid or finish high during reset");
			n_fail++;
		end

	// Finish is sticky
	a_finish_sticky: assert property (@(posedge clk) disable iff (!rst) !$fell(finish))
		else begin
			$error("finish fell while out of reset");
			n_fail++;
		end

	// First result two clocks after START is taken
	a_first_result: assert property (@(posedge clk) disable iff (!rst)
		(state == conv_pkg::ST_WAIT && ctrl == conv_pkg::CTRL_START) |=> ##1 res_valid)
		else begin
			$error("no result after the first compute cycle");
			n_fail++;
		end

endmodule

bind conv_ctrl conv_array_props i_props (
	.clk       (clk),
	.rst       (rst),
	.ctrl      (ctrl),
	.state     (state),
	.res_valid (res_valid),
	.finish    (finish)
);

/* conv_ctrl.sv */
`timescale 1ns/10ps

module conv_ctrl (
	input  logic            clk,
	input  logic            rst,
	input  conv_pkg::ctrl_t ctrl,
	input  logic            i_valid,
	input  logic            w_valid,
	output logic            row_load,
	output logic            w_load,
	output logic            rotate,
	output logic            w_clear,
	output logic            res_valid,
	output logic            finish
);

	conv_pkg::state_t state;      // Current state
	conv_pkg::state_t state_nxt;  // Decoded next state

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= conv_pkg::ST_WAIT;
			res_valid <= 1'b0;
		end else begin
			state     <= state_nxt;
			res_valid <= (state == conv_pkg::ST_COMPUTE);  // Result of this cycle lands next edge
		end
	end

	always_comb begin
		state_nxt = state;  // Default stay
		case (state)
			conv_pkg::ST_WAIT: begin
				if (ctrl == conv_pkg::CTRL_START)
					state_nxt = conv_pkg::ST_COMPUTE;
				else if (ctrl == conv_pkg::CTRL_END)
					state_nxt = conv_pkg::ST_FINISH;
			end
			conv_pkg::ST_COMPUTE: begin
				if (ctrl == conv_pkg::CTRL_HOLD)
					state_nxt = conv_pkg::ST_WAIT;  // Pause for new data
				else if (ctrl == conv_pkg::CTRL_END)
					state_nxt = conv_pkg::ST_FINISH;
			end
			conv_pkg::ST_FINISH: begin
				state_nxt = conv_pkg::ST_FINISH;  // Only reset leaves
			end
			default: begin
				state_nxt = conv_pkg::ST_WAIT;  // Unused encoding
			end
		endcase
	end

	// Loads only while waiting, rows win over weights
	assign row_load = (state == conv_pkg::ST_WAIT) && i_valid;
	assign w_load   = (state == conv_pkg::ST_WAIT) && w_valid && !i_valid;

	assign rotate   = (state == conv_pkg::ST_COMPUTE);  // Every compute clock

	// Restart weight fill on the hold edge
	assign w_clear  = (state == conv_pkg::ST_COMPUTE) && (ctrl == conv_pkg::CTRL_HOLD);

	assign finish   = (state == conv_pkg::ST_FINISH);

endmodule

/* conv_pkg.sv */
package conv_pkg;

	// Datapath widths
	localparam int PIX_W  = 8;               // Pixel and weight
	localparam int LANES  = 8;               // Pixels per row word
	localparam int ROWS   = 8;               // Row registers
	localparam int KSIZE  = 3;               // Kernel side
	localparam int KTAPS  = KSIZE * KSIZE;   // Taps per kernel
	localparam int WORD_W = LANES * PIX_W;   // Load word
	localparam int PROD_W = 2 * PIX_W;       // One unsigned product
	localparam int SUM_W  = PROD_W + 4;      // Nine products plus guard bits

	// Byte b is column b
	typedef logic [LANES-1:0][PIX_W-1:0] row_t;

	// Tap j is kernel row j/3, column j%3
	typedef logic [KTAPS-1:0][PIX_W-1:0] kernel_t;

	typedef logic [SUM_W-1:0] sum_t;

	// Control code from the host
	typedef enum logic [1:0] {
		CTRL_END   = 2'd0,  // Go to finish
		CTRL_START = 2'd1,  // Begin computing
		CTRL_HOLD  = 2'd2,  // Back to loading
		CTRL_IDLE  = 2'd3   // No request
	} ctrl_t;

	typedef enum logic [1:0] {
		ST_WAIT    = 2'd0,  // Loads accepted
		ST_COMPUTE = 2'd1,  // Rows rotate every clock
		ST_FINISH  = 2'd2   // Sticky until reset
	} state_t;

endpackage

/* conv_row_buffer.sv */
`timescale 1ns/10ps

module conv_row_buffer (
	input  logic           clk,
	input  logic           rst,
	input  conv_pkg::row_t i_data,
	input  logic           row_load,
	input  logic           rotate,
	input  logic           stride,
	output conv_pkg::row_t row0,
	output conv_pkg::row_t row1,
	output conv_pkg::row_t row2
);

	conv_pkg::row_t rows [conv_pkg::ROWS];  // Row 0 is the oldest

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int r = 0; r < conv_pkg::ROWS; r++) begin
				rows[r] <= '0;
			end
		end else if (row_load) begin
			// Shift down, new word on top
			for (int r = 0; r < conv_pkg::ROWS - 1; r++) begin
				rows[r] <= rows[r + 1];
			end
			rows[conv_pkg::ROWS - 1] <= i_data;
		end else if (rotate) begin
			// Cyclic step of one or two rows
			for (int r = 0; r < conv_pkg::ROWS; r++) begin
				if (stride)
					rows[r] <= rows[(r + 2) % conv_pkg::ROWS];  // Stride two
				else
					rows[r] <= rows[(r + 1) % conv_pkg::ROWS];  // Stride one
			end
		end
	end

	// Window rows for the 3x3 cubes
	assign row0 = rows[0];
	assign row1 = rows[1];
	assign row2 = rows[2];

endmodule

/* conv_weight_buffer.sv */
`timescale 1ns/10ps

module conv_weight_buffer #(
	parameter int KERNELS = 2
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [conv_pkg::WORD_W-1:0]           w_data,
	input  logic                                  w_load,
	input  logic                                  w_clear,
	output conv_pkg::kernel_t [KERNELS-1:0]       kernels
);

	localparam int NBYTES = conv_pkg::KTAPS * KERNELS;                  // Bytes actually used
	localparam int NWORDS = (NBYTES + conv_pkg::LANES - 1) / conv_pkg::LANES;  // Whole words
	localparam int IDX_W  = $clog2(NWORDS);                             // Word slot index
	localparam int CNT_W  = $clog2(NWORDS + 1);                         // Count up to full
	localparam int KBITS  = conv_pkg::KTAPS * conv_pkg::PIX_W;          // One kernel

	logic [NWORDS*conv_pkg::WORD_W-1:0] wmem;  // Flat byte store, byte 0 at bit 0
	logic [CNT_W-1:0]                   wcnt;  // Words written since clear
	logic                               wfull; // Extra words dropped

	assign wfull = (wcnt == CNT_W'(NWORDS));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wmem <= '0;
			wcnt <= '0;
		end else if (w_clear) begin
			wcnt <= '0;  // Old weights kept until overwritten
		end else if (w_load && !wfull) begin
			wmem[wcnt[IDX_W-1:0]*conv_pkg::WORD_W +: conv_pkg::WORD_W] <= w_data;
			wcnt <= wcnt + CNT_W'(1);  // Saturates at NWORDS
		end
	end

	// Kernel k tap j is flat byte 9k+j
	always_comb begin
		for (int k = 0; k < KERNELS; k++) begin
			kernels[k] = wmem[k*KBITS +: KBITS];
		end
	end

endmodule

/* conv_window_cube.sv */
`timescale 1ns/10ps

module conv_window_cube #(
	parameter int COL = 0
) (
	input  logic              clk,
	input  logic              rst,
	input  conv_pkg::row_t    row0,
	input  conv_pkg::row_t    row1,
	input  conv_pkg::row_t    row2,
	input  conv_pkg::kernel_t kernel,
	output conv_pkg::sum_t    sum
);

	conv_pkg::row_t              win_rows [conv_pkg::KSIZE];  // Kernel row r uses win_rows[r]
	logic [conv_pkg::PROD_W-1:0] prod [conv_pkg::KTAPS];      // One product per tap
	conv_pkg::sum_t              acc;                          // Dot product before register

	assign win_rows[0] = row0;
	assign win_rows[1] = row1;
	assign win_rows[2] = row2;

	always_comb begin
		acc = '0;
		for (int r = 0; r < conv_pkg::KSIZE; r++) begin
			for (int q = 0; q < conv_pkg::KSIZE; q++) begin
				// Columns wrap past the right edge
				prod[r*conv_pkg::KSIZE + q] =
					conv_pkg::PROD_W'(win_rows[r][(COL + q) % conv_pkg::LANES]) *
					conv_pkg::PROD_W'(kernel[r*conv_pkg::KSIZE + q]);
				acc = acc + conv_pkg::SUM_W'(prod[r*conv_pkg::KSIZE + q]);
			end
		end
	end

	// Registered every clock, res_valid tells which count
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			sum <= '0;
		else
			sum <= acc;
	end

endmodule

/* tb_conv_array.sv */
`timescale 1ns/10ps

module tb_conv_array;

	localparam int KERNELS    = 2;
	localparam int NLANE      = KERNELS * conv_pkg::LANES;                     // Result lanes
	localparam int NWORDS     = (conv_pkg::KTAPS * KERNELS + conv_pkg::LANES - 1) / conv_pkg::LANES;
	localparam int NWBYTES    = NWORDS * conv_pkg::LANES;                      // Weight bytes stored
	localparam int N_TESTS    = 6;
	localparam int N_COMPUTE  = 16;                                            // 1 + 8 + 4 + 2 + 1
	localparam int TIMEOUT_NS = (50 * N_TESTS + N_COMPUTE) * 10;

	logic                              clk;
	logic                              rst;
	conv_pkg::ctrl_t                   ctrl;
	logic [conv_pkg::WORD_W-1:0]       i_data;
	logic [conv_pkg::WORD_W-1:0]       w_data;
	logic                              i_valid;
	logic                              w_valid;
	logic                              stride;
	conv_pkg::sum_t [NLANE-1:0]        result;
	logic                              res_valid;
	logic                              finish;

	conv_pkg::row_t             m_rows [conv_pkg::ROWS];  // Model rows, 0 oldest
	logic [conv_pkg::PIX_W-1:0] m_w [NWBYTES];            // Model flat weight bytes
	int                         m_cnt;                    // Model weight word count
	conv_pkg::state_t           m_state;
	conv_pkg::sum_t             exp_sum [NLANE];          // Sums of the last compute cycle
	logic                       exp_valid;                // Result due this cycle

	integer seed = 32'h5aad;
	string  test_name;
	int     test_errors;
	int     n_seen;      // res_valid pulses in current test
	int     n_tests = 0;
	int     n_checks = 0;
	int     n_errors = 0;

	conv_array #(
		.KERNELS (KERNELS)
	) i_dut (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl),
		.i_data    (i_data),
		.w_data    (w_data),
		.i_valid   (i_valid),
		.w_valid   (w_valid),
		.stride    (stride),
		.result    (result),
		.res_valid (res_valid),
		.finish    (finish)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;  // 10 ns period

	// Expected dot product for kernel k, column lane c
	function automatic conv_pkg::sum_t ref_sum(input int k, input int c);
		int acc;
		acc = 0;
		for (int r = 0; r < conv_pkg::KSIZE; r++)
			for (int q = 0; q < conv_pkg::KSIZE; q++)
				acc += int'(m_rows[r][(c + q) % conv_pkg::LANES]) *
					int'(m_w[conv_pkg::KTAPS*k + conv_pkg::KSIZE*r + q]);
		return conv_pkg::sum_t'(acc);
	endfunction

	function automatic logic [conv_pkg::WORD_W-1:0] rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	// Model follows the same edges as the DUT
	always @(posedge clk) begin
		conv_pkg::row_t tmp [conv_pkg::ROWS];
		if (!rst) begin
			for (int r = 0; r < conv_pkg::ROWS; r++) m_rows[r] = '0;
			for (int b = 0; b < NWBYTES; b++) m_w[b] = '0;
			m_cnt     = 0;
			m_state   = conv_pkg::ST_WAIT;
			exp_valid = 1'b0;
		end else begin
			exp_valid = (m_state == conv_pkg::ST_COMPUTE);
			if (exp_valid)
				for (int l = 0; l < NLANE; l++)
					exp_sum[l] = ref_sum(l / conv_pkg::LANES, l % conv_pkg::LANES);
			case (m_state)
				conv_pkg::ST_WAIT: begin
					if (i_valid) begin  // Rows beat weights
						for (int r = 0; r < conv_pkg::ROWS - 1; r++) m_rows[r] = m_rows[r + 1];
						m_rows[conv_pkg::ROWS - 1] = i_data;
					end else if (w_valid && m_cnt < NWORDS) begin
						for (int b = 0; b < conv_pkg::LANES; b++)
							m_w[m_cnt*conv_pkg::LANES + b] = w_data[b*conv_pkg::PIX_W +: conv_pkg::PIX_W];
						m_cnt++;
					end
					if (ctrl == conv_pkg::CTRL_START) m_state = conv_pkg::ST_COMPUTE;
					else if (ctrl == conv_pkg::CTRL_END) m_state = conv_pkg::ST_FINISH;
				end
				conv_pkg::ST_COMPUTE: begin
					tmp = m_rows;
					for (int r = 0; r < conv_pkg::ROWS; r++)
						m_rows[r] = tmp[(r + (stride ? 2 : 1)) % conv_pkg::ROWS];
					if (ctrl == conv_pkg::CTRL_HOLD) begin
						m_cnt   = 0;  // Count only, bytes stay
						m_state = conv_pkg::ST_WAIT;
					end else if (ctrl == conv_pkg::CTRL_END) begin
						m_state = conv_pkg::ST_FINISH;
					end
				end
				default: ;  // Finish is sticky
			endcase
		end
	end

	task automatic check_sum(input string what, input conv_pkg::sum_t exp,
		input conv_pkg::sum_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			test_errors++;
			$display("FAIL %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			test_errors++;
			$display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		n_checks++;
		if (act != exp) begin
			n_errors++;
			test_errors++;
			$display("FAIL %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rst) begin
			check_flag("res_valid", exp_valid, res_valid);
			check_flag("finish", m_state == conv_pkg::ST_FINISH, finish);
			if (res_valid) begin
				n_seen++;
				if (exp_valid)
					for (int l = 0; l < NLANE; l++)
						check_sum($sformatf("lane %0d", l), exp_sum[l], result[l]);
			end
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;  // Drive just after the edge
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
		n_seen      = 0;
	endtask

	task automatic end_test();
		n_tests++;
		$display("test %s: %s, %0d results, %0d errors", test_name,
			(test_errors == 0) ? "ok" : "failed", n_seen, test_errors);
	endtask

	task automatic load_row(input logic [conv_pkg::WORD_W-1:0] d);
		i_valid = 1'b1;
		i_data  = d;
		next_cycle();
		i_valid = 1'b0;
	endtask

	task automatic load_weight(input logic [conv_pkg::WORD_W-1:0] d);
		w_valid = 1'b1;
		w_data  = d;
		next_cycle();
		w_valid = 1'b0;
	endtask

	task automatic load_all();
		for (int r = 0; r < conv_pkg::ROWS; r++) load_row(rand_word());
	endtask

	// START, n compute cycles, HOLD on the last
	task automatic run_compute(input int n, input logic s);
		stride = s;
		ctrl   = conv_pkg::CTRL_START;
		next_cycle();
		ctrl = conv_pkg::CTRL_IDLE;
		repeat (n - 1) next_cycle();
		ctrl = conv_pkg::CTRL_HOLD;
		next_cycle();
		ctrl = conv_pkg::CTRL_IDLE;
		wait (n_seen >= n);
		repeat (2) next_cycle();  // Catch extra pulses
		check_count("results", n, n_seen);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the tests did not finish in %0d ns", TIMEOUT_NS);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		ctrl    = conv_pkg::CTRL_IDLE;
		i_data  = '0;
		w_data  = '0;
		i_valid = 1'b0;
		w_valid = 1'b0;
		stride  = 1'b0;
		rst     = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst = 1'b1;

		begin_test("reset");
		check_flag("res_valid", 1'b0, res_valid);
		check_flag("finish", 1'b0, finish);
		for (int l = 0; l < NLANE; l++) check_sum($sformatf("lane %0d", l), '0, result[l]);
		end_test();

		begin_test("single_cycle");
		load_all();
		for (int w = 0; w < NWORDS; w++) load_weight(rand_word());
		run_compute(1, 1'b0);
		end_test();

		begin_test("stride0");
		run_compute(8, 1'b0);  // Full turn of the rows
		end_test();

		begin_test("stride1");
		run_compute(4, 1'b1);
		end_test();

		begin_test("weight_reload");
		for (int w = 0; w < NWORDS; w++) load_weight(rand_word());
		load_all();
		run_compute(2, 1'b0);
		end_test();

		begin_test("end");
		stride = 1'b0;
		ctrl   = conv_pkg::CTRL_START;
		next_cycle();
		ctrl = conv_pkg::CTRL_END;
		next_cycle();
		ctrl = conv_pkg::CTRL_IDLE;
		wait (n_seen >= 1);
		load_row(rand_word());  // Ignored once finished
		ctrl = conv_pkg::CTRL_START;
		repeat (4) next_cycle();
		ctrl = conv_pkg::CTRL_IDLE;
		next_cycle();
		check_count("results", 1, n_seen);
		check_flag("finish", 1'b1, finish);
		end_test();

		n_errors += i_dut.i_ctrl.i_props.n_fail;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			n_tests, n_checks, n_errors, i_dut.i_ctrl.i_props.n_fail);
		if (n_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* verilog.f */
conv_pkg.sv
conv_ctrl.sv
conv_row_buffer.sv
conv_weight_buffer.sv
conv_window_cube.sv
conv_array.sv
conv_array_props.sv
tb_conv_array.sv
